//--- rtl/perint_defines.svh
// PerInt subsystem parameters
// bus geometry, memory banking, UART buffering and the address map
`ifndef PERINT_DEFINES_SVH
`define PERINT_DEFINES_SVH

// data path width in bits, and the word address left after dropping the byte offset
`define PI1R_ARCHBITSZ 32
`define PI1R_ADDRBITSZ 30
`define PI1R_SELBITSZ  4

// the memory is SMEM_BANK_COUNT banks of SMEM_BANK_WORDS words, 4 KB in total
`define SMEM_BANK_COUNT 4
`define SMEM_BANK_WORDS 256

// word addresses, so memory sits at byte 0x1000 and the UART in the two words below it
`define SMEM_BASE_WORD 'h400
`define UART_BASE_WORD 'h3FE

// depth of the UART transmit byte buffer
`define UART_BUFSZ 2

`endif

//--- rtl/pi1r_pkg.sv
// PerInt bus types
// operation code plus the request and response bundles shared by master and devices
`include "perint_defines.svh"

package pi1r_pkg;

	// encoding follows the PerInt op field, swap is a read-write that returns the old word
	typedef enum logic [1:0] {
		PI1R_OP_NONE  = 2'b00,
		PI1R_OP_WRITE = 2'b01,
		PI1R_OP_READ  = 2'b10,
		PI1R_OP_SWAP  = 2'b11
	} pi1r_op_e;

	// request from the master, held steady while op is not none
	// addr is a word address, sel picks the active byte lanes
	typedef struct packed {
		pi1r_op_e                    op;
		logic [`PI1R_ADDRBITSZ-1:0] addr;
		logic [`PI1R_ARCHBITSZ-1:0] data;
		logic [`PI1R_SELBITSZ-1:0]  sel;
	} pi1r_req_s;

	// response from a device
	// the transaction completes in the cycle rdy is high, and read data is valid then
	typedef struct packed {
		logic [`PI1R_ARCHBITSZ-1:0] data;
		logic                        rdy;
	} pi1r_rsp_s;

endpackage

//--- rtl/perint_map_pkg.sv
// PerInt address map types
// device index and the select that routes a response back to the master
`include "perint_defines.svh"

package perint_map_pkg;

	// devices on the bus, the invalid device catches every unmapped address
	typedef enum logic [1:0] {
		PI1R_DEV_UART    = 2'd0,
		PI1R_DEV_MEM     = 2'd1,
		PI1R_DEV_INVALID = 2'd2
	} pi1r_dev_e;

	// which device answers, and for memory which bank inside it
	// bank only means something when dev is the memory
	typedef struct packed {
		pi1r_dev_e                         dev;
		logic [$clog2(`SMEM_BANK_COUNT)-1:0] bank;
	} pi1r_devsel_s;

endpackage

//--- rtl/pi1r_decode.sv
// PerInt address decoder
// routes the master request to one bank or the UART and reports which device answers
`timescale 1ns/1ps
`include "perint_defines.svh"

module pi1r_decode (
	input  pi1r_pkg::pi1r_req_s          req_i,
	output pi1r_pkg::pi1r_req_s          bank_req_o [`SMEM_BANK_COUNT],
	output pi1r_pkg::pi1r_req_s          uart_req_o,
	output perint_map_pkg::pi1r_devsel_s devsel_o
);

	localparam int BANK_AW    = $clog2(`SMEM_BANK_WORDS);
	localparam int BANK_BW    = $clog2(`SMEM_BANK_COUNT);
	localparam int MEM_WORDS  = `SMEM_BANK_COUNT * `SMEM_BANK_WORDS;
	localparam int UART_WORDS = 2;

	// word offsets relative to each region base
	logic [`PI1R_ADDRBITSZ-1:0] mem_off;
	logic [`PI1R_ADDRBITSZ-1:0] uart_off;
	logic                       mem_hit;
	logic                       uart_hit;
	logic                       op_active;

	// an address below a base wraps to a huge offset, so one unsigned compare per region
	// is enough to test both ends of the range
	assign mem_off   = req_i.addr - `PI1R_ADDRBITSZ'(`SMEM_BASE_WORD);
	assign uart_off  = req_i.addr - `PI1R_ADDRBITSZ'(`UART_BASE_WORD);
	assign mem_hit   = mem_off < `PI1R_ADDRBITSZ'(MEM_WORDS);
	assign uart_hit  = uart_off < `PI1R_ADDRBITSZ'(UART_WORDS);
	assign op_active = req_i.op != pi1r_pkg::PI1R_OP_NONE;

	// every bank sees the same in-bank offset, only the addressed one gets a live op
	always_comb begin
		for (int b = 0; b < `SMEM_BANK_COUNT; b++) begin
			bank_req_o[b]      = req_i;
			bank_req_o[b].addr = `PI1R_ADDRBITSZ'(mem_off[BANK_AW-1:0]);
			if (!(mem_hit && (mem_off[BANK_AW +: BANK_BW] == BANK_BW'(b)))) begin
				bank_req_o[b].op = pi1r_pkg::PI1R_OP_NONE;
			end
		end
	end

	// the UART only needs offset 0 or 1
	always_comb begin
		uart_req_o      = req_i;
		uart_req_o.addr = uart_off;
		if (!uart_hit) begin
			uart_req_o.op = pi1r_pkg::PI1R_OP_NONE;
		end
	end

	// an idle bus parks the select on bank 0, which keeps rdy low while it sees no op
	// otherwise the invalid device would answer an idle bus at once
	always_comb begin
		devsel_o.dev  = perint_map_pkg::PI1R_DEV_MEM;
		devsel_o.bank = '0;
		if (op_active) begin
			if (mem_hit) begin
				devsel_o.bank = mem_off[BANK_AW +: BANK_BW];
			end else if (uart_hit) begin
				devsel_o.dev = perint_map_pkg::PI1R_DEV_UART;
			end else begin
				devsel_o.dev = perint_map_pkg::PI1R_DEV_INVALID;
			end
		end
	end

endmodule

//--- rtl/smem_bank.sv
// on-chip memory bank
// word array with byte selects, answering read, write and swap in two cycles
`timescale 1ns/1ps
`include "perint_defines.svh"

module smem_bank (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  pi1r_pkg::pi1r_req_s req_i,
	output pi1r_pkg::pi1r_rsp_s rsp_o
);

	localparam int AW = $clog2(`SMEM_BANK_WORDS);

	logic [`PI1R_ARCHBITSZ-1:0] mem_q [`SMEM_BANK_WORDS];

	// request captured in the first cycle of an operation
	pi1r_pkg::pi1r_op_e         op_q;
	logic [AW-1:0]              addr_q;
	logic [`PI1R_ARCHBITSZ-1:0] wdata_q;
	logic [`PI1R_SELBITSZ-1:0]  sel_q;
	logic [`PI1R_ARCHBITSZ-1:0] rdata_q;

	// high in the second cycle, which is the completion cycle
	logic                       done_q;
	logic                       start;
	logic [`PI1R_SELBITSZ-1:0]  byte_we;

	// the request is still on the bus during the completion cycle, so it is not taken again
	assign start = (req_i.op != pi1r_pkg::PI1R_OP_NONE) && !done_q;

	// write and swap both store at the end of the completion cycle
	assign byte_we = sel_q & {`PI1R_SELBITSZ{done_q &&
		((op_q == pi1r_pkg::PI1R_OP_WRITE) || (op_q == pi1r_pkg::PI1R_OP_SWAP))}};

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			done_q <= 1'b0;
			op_q   <= pi1r_pkg::PI1R_OP_NONE;
		end else begin
			done_q <= start;
			if (start) begin
				op_q <= req_i.op;
			end
		end
	end

	// the old word is read when the request is taken, so swap returns what was there
	always_ff @(posedge clk_i) begin
		if (start) begin
			addr_q  <= req_i.addr[AW-1:0];
			wdata_q <= req_i.data;
			sel_q   <= req_i.sel;
			rdata_q <= mem_q[req_i.addr[AW-1:0]];
		end
	end

	always_ff @(posedge clk_i) begin
		for (int b = 0; b < `PI1R_SELBITSZ; b++) begin
			if (byte_we[b]) begin
				mem_q[addr_q][b*8 +: 8] <= wdata_q[b*8 +: 8];
			end
		end
	end

	assign rsp_o.data = rdata_q;
	assign rsp_o.rdy  = done_q;

endmodule

//--- rtl/uart_tx_sink.sv
// UART transmit device
// bus writes fill a small byte FIFO that drains through a valid/ready stream
`timescale 1ns/1ps
`include "perint_defines.svh"

module uart_tx_sink (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  pi1r_pkg::pi1r_req_s req_i,
	output pi1r_pkg::pi1r_rsp_s rsp_o,
	output logic [7:0]          tx_data_o,
	output logic                tx_valid_o,
	input  logic                tx_ready_i
);

	localparam int DEPTH = `UART_BUFSZ;
	localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW    = $clog2(DEPTH + 1);

	logic [7:0]    buf_q [DEPTH];
	logic [PW-1:0] wr_ptr_q;
	logic [PW-1:0] rd_ptr_q;
	logic [CW-1:0] count_q;

	logic          op_active;
	logic          tx_write;
	logic          full;
	logic          push;
	logic          pop;
	logic [7:0]    wr_byte;

	assign op_active = req_i.op != pi1r_pkg::PI1R_OP_NONE;
	assign full      = count_q == CW'(DEPTH);

	// a swap to offset 0 also sends its byte, writes to offset 1 are dropped
	assign tx_write = ((req_i.op == pi1r_pkg::PI1R_OP_WRITE) ||
		(req_i.op == pi1r_pkg::PI1R_OP_SWAP)) && !req_i.addr[0];
	assign push     = tx_write && !full;
	assign pop      = tx_valid_o && tx_ready_i;

	// the byte comes from the lowest enabled lane, walking down so the lowest one wins
	always_comb begin
		wr_byte = req_i.data[7:0];
		for (int b = `PI1R_SELBITSZ - 1; b >= 0; b--) begin
			if (req_i.sel[b]) begin
				wr_byte = req_i.data[b*8 +: 8];
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			end
			case ({push, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (push) begin
			buf_q[wr_ptr_q] <= wr_byte;
		end
	end

	assign tx_data_o  = buf_q[rd_ptr_q];
	assign tx_valid_o = count_q != '0;

	// a byte write waits for a free slot, everything else completes at once
	// offset 1 reads back the free slot count, offset 0 reads zero
	assign rsp_o.rdy  = op_active && !(tx_write && full);
	assign rsp_o.data = req_i.addr[0] ? `PI1R_ARCHBITSZ'(CW'(DEPTH) - count_q) : '0;

endmodule

//--- rtl/pi1r_respmux.sv
// PerInt response multiplexer
// hands the selected device's answer back to the master, the invalid device lives here
`timescale 1ns/1ps
`include "perint_defines.svh"

module pi1r_respmux (
	input  pi1r_pkg::pi1r_rsp_s          bank_rsp_i [`SMEM_BANK_COUNT],
	input  pi1r_pkg::pi1r_rsp_s          uart_rsp_i,
	input  perint_map_pkg::pi1r_devsel_s devsel_i,
	output pi1r_pkg::pi1r_rsp_s          rsp_o
);

	always_comb begin
		case (devsel_i.dev)
			perint_map_pkg::PI1R_DEV_MEM: begin
				rsp_o = bank_rsp_i[devsel_i.bank];
			end
			perint_map_pkg::PI1R_DEV_UART: begin
				rsp_o = uart_rsp_i;
			end
			default: begin
				// unmapped space completes in the same cycle and reads as zero
				rsp_o.data = '0;
				rsp_o.rdy  = 1'b1;
			end
		endcase
	end

endmodule

//--- rtl/perint_sys.sv
// PerInt subsystem top level
// one master port reaching banked on-chip memory and a UART transmitter
`timescale 1ns/1ps
`include "perint_defines.svh"

module perint_sys (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  pi1r_pkg::pi1r_req_s req_i,
	output pi1r_pkg::pi1r_rsp_s rsp_o,
	output logic [7:0]          tx_data_o,
	output logic                tx_valid_o,
	input  logic                tx_ready_i
);

	pi1r_pkg::pi1r_req_s          bank_req [`SMEM_BANK_COUNT];
	pi1r_pkg::pi1r_rsp_s          bank_rsp [`SMEM_BANK_COUNT];
	pi1r_pkg::pi1r_req_s          uart_req;
	pi1r_pkg::pi1r_rsp_s          uart_rsp;
	perint_map_pkg::pi1r_devsel_s devsel;

	// the decoder and the mux are combinational, so latency is that of the device
	pi1r_decode u_decode (
		.req_i      (req_i),
		.bank_req_o (bank_req),
		.uart_req_o (uart_req),
		.devsel_o   (devsel)
	);

	// consecutive 1 KB slices of the memory window, one bank each
	for (genvar g = 0; g < `SMEM_BANK_COUNT; g++) begin : g_bank
		smem_bank u_bank (
			.clk_i   (clk_i),
			.rst_n_i (rst_n_i),
			.req_i   (bank_req[g]),
			.rsp_o   (bank_rsp[g])
		);
	end

	uart_tx_sink u_uart (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.req_i      (uart_req),
		.rsp_o      (uart_rsp),
		.tx_data_o  (tx_data_o),
		.tx_valid_o (tx_valid_o),
		.tx_ready_i (tx_ready_i)
	);

	pi1r_respmux u_respmux (
		.bank_rsp_i (bank_rsp),
		.uart_rsp_i (uart_rsp),
		.devsel_i   (devsel),
		.rsp_o      (rsp_o)
	);

endmodule

//--- verification/perint_sys_tb.sv
// testbench for the PerInt subsystem
// plays the bus master, models the memory and watches the UART stream
`timescale 1ns/1ps
`include "perint_defines.svh"

module perint_sys_tb;

	localparam int MEM_WORDS = `SMEM_BANK_COUNT * `SMEM_BANK_WORDS;
	// about 110 bus operations of at most four cycles each, plus reset and the UART stall
	localparam int OP_COUNT   = 110;
	localparam int RUN_CYCLES = 8 + OP_COUNT * 4 + 20;
	localparam int TIMEOUT_NS = RUN_CYCLES * 2 * 40;

	logic                clk_i = 1'b0;
	logic                rst_n_i;
	logic                tx_ready_i;
	pi1r_pkg::pi1r_req_s req_i;
	pi1r_pkg::pi1r_rsp_s rsp_o;
	logic [7:0]          tx_data_o;
	logic                tx_valid_o;

	// word model of the whole 4 KB window, indexed by offset from the memory base
	logic [31:0] mem_model [MEM_WORDS];
	logic [29:0] used_q [$];
	// completed reads wait here until the compare process takes them
	logic [31:0] got_q [$];
	logic [31:0] exp_q [$];
	string       name_q [$];
	logic [7:0]  byte_q [$];
	logic [31:0] rng = 32'd43948;
	int          errors = 0;
	int          err_mark = 0;
	int          pushed = 0;
	int          compared = 0;
	int          bytes_seen = 0;

	perint_sys dut (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.req_i      (req_i),
		.rsp_o      (rsp_o),
		.tx_data_o  (tx_data_o),
		.tx_valid_o (tx_valid_o),
		.tx_ready_i (tx_ready_i)
	);

	always #20 clk_i = ~clk_i;

	// xorshift32, one step per call
	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// memory words come from the model and every unmapped word reads as zero
	function automatic logic [31:0] expected_read(logic [29:0] addr);
		if (addr >= `SMEM_BASE_WORD && addr < `SMEM_BASE_WORD + MEM_WORDS) begin
			return mem_model[addr - `SMEM_BASE_WORD];
		end
		return '0;
	endfunction

	// the UART sends the byte in the lowest enabled lane
	function automatic logic [7:0] lane_byte(logic [31:0] data, logic [3:0] sel);
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				return data[b*8 +: 8];
			end
		end
		return data[7:0];
	endfunction

	task automatic model_write(logic [29:0] addr, logic [31:0] data, logic [3:0] sel);
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				mem_model[addr - `SMEM_BASE_WORD][b*8 +: 8] = data[b*8 +: 8];
			end
		end
	endtask

	// holds the request until rdy, sampled at the falling edge where it is stable
	task automatic bus_op(pi1r_pkg::pi1r_op_e op, logic [29:0] addr, logic [31:0] data,
		logic [3:0] sel, output logic [31:0] rdata);
		@(posedge clk_i);
		#2;
		req_i.op   = op;
		req_i.addr = addr;
		req_i.data = data;
		req_i.sel  = sel;
		do begin
			@(negedge clk_i);
		end while (!rsp_o.rdy);
		rdata = rsp_o.data;
		@(posedge clk_i);
		#2;
		req_i.op = pi1r_pkg::PI1R_OP_NONE;
	endtask

	task automatic expect_word(string name, logic [31:0] got, logic [31:0] exp);
		got_q.push_back(got);
		exp_q.push_back(exp);
		name_q.push_back(name);
		pushed++;
	endtask

	// waits until every queued read has been compared, then reports the test
	task automatic finish_test(string name);
		wait (compared == pushed);
		if (errors == err_mark) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	initial begin : compare
		logic [31:0] got;
		logic [31:0] exp;
		string       name;
		forever begin
			wait (got_q.size() != 0);
			got  = got_q.pop_front();
			exp  = exp_q.pop_front();
			name = name_q.pop_front();
			assert (got === exp) else begin
				$display("ERROR t=%0t %s got %08h expected %08h", $time, name, got, exp);
				errors++;
			end
			compared++;
		end
	end

	// a byte moves at the next rising edge when valid and ready are both high here
	always @(negedge clk_i) begin : stream_check
		logic [7:0] exp_byte;
		if (rst_n_i && tx_valid_o && tx_ready_i) begin
			assert (byte_q.size() != 0) else begin
				$display("the UART sent byte %02h that no bus write asked for", tx_data_o);
				errors++;
			end
			if (byte_q.size() != 0) begin
				exp_byte = byte_q.pop_front();
				assert (tx_data_o === exp_byte) else begin
					$display("ERROR t=%0t tx_data_o got %02h expected %02h",
						$time, tx_data_o, exp_byte);
					errors++;
				end
			end
			bytes_seen++;
		end
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin : main
		logic [31:0] rdata;
		logic [29:0] addr;
		logic [31:0] data;
		logic [3:0]  sel;
		logic        stall_done;
		req_i      = '0;
		rst_n_i    = 1'b0;
		tx_ready_i = 1'b0;
		repeat (8) @(posedge clk_i);
		#2;
		rst_n_i = 1'b1;

		// an idle bus parks on a bank, so nothing answers and the stream is empty
		@(negedge clk_i);
		expect_word("rsp_o.rdy", rsp_o.rdy, 0);
		expect_word("tx_valid_o", tx_valid_o, 0);
		finish_test("reset");

		// four words in each bank, in bank order
		for (int i = 0; i < 16; i++) begin
			addr = `SMEM_BASE_WORD + (i % 4) * `SMEM_BANK_WORDS + next_rand() % `SMEM_BANK_WORDS;
			data = next_rand();
			bus_op(pi1r_pkg::PI1R_OP_WRITE, addr, data, 4'hF, rdata);
			model_write(addr, data, 4'hF);
			used_q.push_back(addr);
		end
		foreach (used_q[i]) begin
			bus_op(pi1r_pkg::PI1R_OP_READ, used_q[i], '0, 4'hF, rdata);
			expect_word("rsp_o.data", rdata, expected_read(used_q[i]));
		end
		finish_test("memory read and write");

		// partial writes go only to words that hold known data
		for (int i = 0; i < 12; i++) begin
			addr = used_q[next_rand() % used_q.size()];
			data = next_rand();
			sel  = 4'(next_rand() % 15 + 1);
			bus_op(pi1r_pkg::PI1R_OP_WRITE, addr, data, sel, rdata);
			model_write(addr, data, sel);
			bus_op(pi1r_pkg::PI1R_OP_READ, addr, '0, 4'hF, rdata);
			expect_word("rsp_o.data", rdata, expected_read(addr));
		end
		finish_test("partial writes");

		for (int i = 0; i < 8; i++) begin
			addr = used_q[i];
			data = next_rand();
			bus_op(pi1r_pkg::PI1R_OP_SWAP, addr, data, 4'hF, rdata);
			expect_word("rsp_o.data", rdata, expected_read(addr));
			model_write(addr, data, 4'hF);
			bus_op(pi1r_pkg::PI1R_OP_READ, addr, '0, 4'hF, rdata);
			expect_word("rsp_o.data", rdata, expected_read(addr));
		end
		finish_test("swap");

		// even steps land below the UART, odd ones above byte address 0x1FFF
		for (int i = 0; i < 8; i++) begin
			if (i % 2 == 0) begin
				addr = 30'(next_rand() % `UART_BASE_WORD);
			end else begin
				addr = 30'('h800 + next_rand() % 32'h3FFF_F800);
			end
			bus_op(pi1r_pkg::PI1R_OP_WRITE, addr, next_rand(), 4'hF, rdata);
			bus_op(pi1r_pkg::PI1R_OP_READ, addr, '0, 4'hF, rdata);
			expect_word("rsp_o.data", rdata, expected_read(addr));
		end
		foreach (used_q[i]) begin
			bus_op(pi1r_pkg::PI1R_OP_READ, used_q[i], '0, 4'hF, rdata);
			expect_word("rsp_o.data", rdata, expected_read(used_q[i]));
		end
		finish_test("invalid address");

		// with ready low every write takes a slot, and offset 1 counts what is left
		bus_op(pi1r_pkg::PI1R_OP_READ, `UART_BASE_WORD, '0, 4'hF, rdata);
		expect_word("rsp_o.data", rdata, 0);
		for (int i = 0; i < `UART_BUFSZ; i++) begin
			data = next_rand();
			sel  = 4'(next_rand() % 15 + 1);
			byte_q.push_back(lane_byte(data, sel));
			bus_op(pi1r_pkg::PI1R_OP_WRITE, `UART_BASE_WORD, data, sel, rdata);
			bus_op(pi1r_pkg::PI1R_OP_READ, `UART_BASE_WORD + 1, '0, 4'hF, rdata);
			expect_word("rsp_o.data", rdata, `UART_BUFSZ - 1 - i);
		end
		data = next_rand();
		byte_q.push_back(data[7:0]);
		stall_done = 1'b0;
		fork
			begin
				bus_op(pi1r_pkg::PI1R_OP_WRITE, `UART_BASE_WORD, data, 4'h1, rdata);
				stall_done = 1'b1;
			end
			begin
				repeat (6) @(negedge clk_i);
				assert (!stall_done) else begin
					$display("a UART write completed while the byte buffer was full");
					errors++;
				end
				@(posedge clk_i);
				#2;
				tx_ready_i = 1'b1;
			end
		join
		wait (byte_q.size() == 0);
		finish_test("UART under back-pressure");

		$display("%0d checks, %0d errors", compared + bytes_seen, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+rtl
rtl/pi1r_pkg.sv
rtl/perint_map_pkg.sv
rtl/pi1r_decode.sv
rtl/smem_bank.sv
rtl/uart_tx_sink.sv
rtl/pi1r_respmux.sv
rtl/perint_sys.sv
verification/perint_sys_tb.sv

//--- Bender.yml
package:
  name: perint_sys

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pi1r_pkg.sv
      - rtl/perint_map_pkg.sv
      - rtl/pi1r_decode.sv
      - rtl/smem_bank.sv
      - rtl/uart_tx_sink.sv
      - rtl/pi1r_respmux.sv
      - rtl/perint_sys.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/perint_sys_tb.sv
